// ==== hdl/cdc_cfg.svh ====
// CDC bridge configuration
`ifndef CDC_CFG_SVH
`define CDC_CFG_SVH

// Width of the word carried across the domains
`define CDC_DATA_WIDTH 8

// Flip-flops in each synchronizer chain
// The bridge needs at least 2
`define CDC_SYNC_STAGES 3

`endif

// ==== hdl/cdc_pkg.sv ====
// CDC bridge types
package cdc_pkg;

    `include "cdc_cfg.svh"

    // Word carried from the source to the destination domain
    typedef logic [`CDC_DATA_WIDTH-1:0] cdc_data_t;

    // Source side handshake states
    typedef enum logic {
        // Ready to take a new word
        SRC_IDLE,
        // Word held until the acknowledge returns
        SRC_WAIT_ACK
    } src_state_t;

endpackage

// ==== hdl/toggle_sync.sv ====
// Level synchronizer chain
`timescale 1ns/100ps

module toggle_sync #(
    parameter int stages = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic level,
    output logic level_sync
);

    // Chain of flops in the receiving domain
    // Bit 0 is the first flop and may go metastable
    logic [stages-1:0] chain;

    always_ff @(posedge clk) begin
        if (reset) begin
            chain <= '0;
        end else begin
            chain <= {chain[stages-2:0], level};
        end
    end

    // Last flop is the settled copy of the level
    assign level_sync = chain[stages-1];

endmodule

// ==== hdl/src_capture.sv ====
// Source domain capture
`timescale 1ns/100ps

module src_capture (
    input  logic               src_clk,
    input  logic               reset,
    input  logic               update,
    input  cdc_pkg::cdc_data_t data_src,
    input  logic               ack_sync,
    output logic               req_toggle,
    output cdc_pkg::cdc_data_t data_hold,
    output logic               busy
);

    import cdc_pkg::*;

    src_state_t state;
    src_state_t state_next;

    // Word is taken only from the idle state
    logic accept;

    // Acknowledge level has caught up with the request level
    logic ack_match;

    assign accept    = (state == SRC_IDLE) && update;
    assign ack_match = (ack_sync == req_toggle);

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            SRC_IDLE: begin
                if (accept) begin
                    state_next = SRC_WAIT_ACK;
                end
            end
            SRC_WAIT_ACK: begin
                // Strobes arriving here are dropped
                if (ack_match) begin
                    state_next = SRC_IDLE;
                end
            end
            default: begin
                state_next = SRC_IDLE;
            end
        endcase
    end

    // State register
    always_ff @(posedge src_clk) begin
        if (reset) begin
            state <= SRC_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request toggle
    // One inversion per accepted word
    always_ff @(posedge src_clk) begin
        if (reset) begin
            req_toggle <= 1'b0;
        end else if (accept) begin
            req_toggle <= ~req_toggle;
        end
    end

    // Held word
    // Stays put for the whole time the request is in flight
    always_ff @(posedge src_clk) begin
        if (accept) begin
            data_hold <= data_src;
        end
    end

    // Busy follows the waiting state directly
    assign busy = (state == SRC_WAIT_ACK);

endmodule

// ==== hdl/dst_capture.sv ====
// Destination domain capture
`timescale 1ns/100ps

module dst_capture (
    input  logic               dst_clk,
    input  logic               reset,
    input  logic               req_sync,
    input  cdc_pkg::cdc_data_t data_hold,
    output cdc_pkg::cdc_data_t data_dst,
    output logic               data_valid,
    output logic               ack_toggle
);

    import cdc_pkg::*;

    // Request level seen at the last transfer
    logic req_last;

    // Synchronized request differs from the last one seen
    logic new_req;

    assign new_req = req_sync ^ req_last;

    // Remember the request level
    // Its value is also the acknowledge level sent back
    always_ff @(posedge dst_clk) begin
        if (reset) begin
            req_last <= 1'b0;
        end else if (new_req) begin
            req_last <= req_sync;
        end
    end

    assign ack_toggle = req_last;

    // One cycle valid pulse per detected edge
    always_ff @(posedge dst_clk) begin
        if (reset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= new_req;
        end
    end

    // Output register
    // data_hold is steady by the time the request edge shows up here
    always_ff @(posedge dst_clk) begin
        if (reset) begin
            data_dst <= '0;
        end else if (new_req) begin
            data_dst <= data_hold;
        end
    end

endmodule

// ==== hdl/multibit_toggle_sync.sv ====
// Multibit toggle CDC bridge
`timescale 1ns/100ps

`include "cdc_cfg.svh"

module multibit_toggle_sync (
    input  logic               src_clk,
    input  logic               dst_clk,
    input  logic               reset,
    input  logic               update,
    input  cdc_pkg::cdc_data_t data_src,
    output logic               busy,
    output cdc_pkg::cdc_data_t data_dst,
    output logic               data_valid
);

    import cdc_pkg::*;

    // Source domain
    logic      req_toggle;
    logic      ack_sync;
    cdc_data_t data_hold;

    // Destination domain
    logic      req_sync;
    logic      ack_toggle;

    src_capture i_src_capture (
        .src_clk    (src_clk),
        .reset      (reset),
        .update     (update),
        .data_src   (data_src),
        .ack_sync   (ack_sync),
        .req_toggle (req_toggle),
        .data_hold  (data_hold),
        .busy       (busy)
    );

    // Request into dst_clk
    toggle_sync #(
        .stages (`CDC_SYNC_STAGES)
    ) i_req_sync (
        .clk        (dst_clk),
        .reset      (reset),
        .level      (req_toggle),
        .level_sync (req_sync)
    );

    dst_capture i_dst_capture (
        .dst_clk    (dst_clk),
        .reset      (reset),
        .req_sync   (req_sync),
        .data_hold  (data_hold),
        .data_dst   (data_dst),
        .data_valid (data_valid),
        .ack_toggle (ack_toggle)
    );

    // Acknowledge back into src_clk
    toggle_sync #(
        .stages (`CDC_SYNC_STAGES)
    ) i_ack_sync (
        .clk        (src_clk),
        .reset      (reset),
        .level      (ack_toggle),
        .level_sync (ack_sync)
    );

endmodule

// ==== verif/tb_multibit_toggle_sync.sv ====
// Multibit toggle CDC bridge testbench
`timescale 1ns/100ps

`include "cdc_cfg.svh"

module tb_multibit_toggle_sync;

    import cdc_pkg::*;

    localparam int src_period = 14;
    localparam int dst_period = 20;
    // Generous bound for one request and acknowledge round trip
    localparam int xfer_ns = (`CDC_SYNC_STAGES + 3) * (src_period + dst_period);
    // Transfers and transfer-length waits over all tests plus margin
    localparam int transfer_budget = 40;
    localparam int watchdog_ns = 10 * dst_period + 2 * transfer_budget * xfer_ns;

    logic      src_clk;
    logic      dst_clk;
    logic      reset;
    logic      update;
    cdc_data_t data_src;
    logic      busy;
    cdc_data_t data_dst;
    logic      data_valid;

    int          mismatch_count;
    int          timeout_count;
    int          pulse_count;
    cdc_data_t   recorded[$];
    logic [31:0] lfsr_state;
    // Word of the last update that the bridge should have taken
    cdc_data_t   last_accepted;

    multibit_toggle_sync i_multibit_toggle_sync (
        .src_clk    (src_clk),
        .dst_clk    (dst_clk),
        .reset      (reset),
        .update     (update),
        .data_src   (data_src),
        .busy       (busy),
        .data_dst   (data_dst),
        .data_valid (data_valid)
    );

    initial begin
        dst_clk = 1'b0;
        forever #(dst_period / 2) dst_clk = ~dst_clk;
    end

    initial begin
        src_clk = 1'b0;
        forever #(src_period / 2) src_clk = ~src_clk;
    end

    // Every data_valid pulse and the word that came with it
    always @(posedge dst_clk) begin
        if (data_valid === 1'b1) begin
            pulse_count++;
            recorded.push_back(data_dst);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("Something failed");
        $finish;
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic cdc_data_t next_word();
        cdc_data_t w;
        int        b;
        w = '0;
        for (b = 0; b < `CDC_DATA_WIDTH; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b] = lfsr_state[0];
        end
        return w;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
        end
    endtask

    // Drive point is 2 ns after a rising src_clk edge
    task automatic next_src_slot();
        @(posedge src_clk);
        #2;
    endtask

    task automatic send_word(input cdc_data_t w);
        data_src = w;
        update = 1'b1;
        next_src_slot();
        update = 1'b0;
    endtask

    task automatic wait_pulses(input int target);
        int waited;
        waited = 0;
        while (pulse_count < target && waited < xfer_ns / src_period * 2) begin
            next_src_slot();
            waited++;
        end
        if (pulse_count < target) begin
            timeout_count++;
            $display("Timeout at %0t ns: no data_valid pulse arrived", $time);
        end
    endtask

    task automatic wait_busy_low();
        int waited;
        waited = 0;
        while (busy !== 1'b0 && waited < xfer_ns / src_period * 2) begin
            next_src_slot();
            waited++;
        end
        if (busy !== 1'b0) begin
            timeout_count++;
            $display("Timeout at %0t ns: busy never fell", $time);
        end
    endtask

    task automatic idle_src_cycles(input int n);
        repeat (n) next_src_slot();
    endtask

    task automatic reset_state_test();
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(data_valid), 32'd0, "data_valid after reset");
        check_value(32'(data_dst), 32'd0, "data_dst after reset");
    endtask

    task automatic single_transfer_test();
        int base;
        base = pulse_count;
        send_word(8'ha5);
        last_accepted = 8'ha5;
        check_value(32'(busy), 32'd1, "busy after accepted update");
        wait_pulses(base + 1);
        wait_busy_low();
        idle_src_cycles(xfer_ns / src_period);
        check_value(pulse_count, base + 1, "pulses for one update");
        if (recorded.size() > base) begin
            check_value(32'(recorded[base]), 32'h0000_00a5, "word of single transfer");
        end
        check_value(32'(data_dst), 32'h0000_00a5, "data_dst after single transfer");
    endtask

    task automatic stream_test();
        cdc_data_t sent[$];
        cdc_data_t w;
        int        base;
        int        i;
        base = pulse_count;
        for (i = 0; i < 20; i++) begin
            w = next_word();
            sent.push_back(w);
            send_word(w);
            last_accepted = w;
            wait_pulses(base + i + 1);
            wait_busy_low();
        end
        check_value(pulse_count, base + 20, "pulses for twenty transfers");
        for (i = 0; i < 20; i++) begin
            if (recorded.size() > base + i) begin
                check_value(32'(recorded[base + i]), 32'(sent[i]), "word in stream order");
            end
        end
    endtask

    task automatic dropped_update_test();
        cdc_data_t first;
        int        base;
        base = pulse_count;
        first = next_word();
        send_word(first);
        last_accepted = first;
        check_value(32'(busy), 32'd1, "busy before second update");
        // Strobe while busy must be dropped
        send_word(~first);
        wait_busy_low();
        idle_src_cycles(2 * xfer_ns / src_period);
        check_value(pulse_count, base + 1, "pulses with an update while busy");
        check_value(32'(data_dst), 32'(first), "data_dst keeps the first word");
        check_value(32'(busy), 32'd0, "busy after drain");
    endtask

    task automatic no_update_test();
        int base;
        base = pulse_count;
        repeat (5 * xfer_ns / src_period) begin
            data_src = next_word();
            next_src_slot();
        end
        check_value(pulse_count, base, "pulses without update");
        check_value(32'(data_dst), 32'(last_accepted), "data_dst without update");
        check_value(32'(busy), 32'd0, "busy without update");
    endtask

    initial begin
        reset = 1'b1;
        update = 1'b0;
        data_src = '0;
        mismatch_count = 0;
        timeout_count = 0;
        pulse_count = 0;
        lfsr_state = 32'hcb32_7879;
        last_accepted = '0;

        repeat (10) @(posedge dst_clk);
        next_src_slot();
        reset = 1'b0;
        idle_src_cycles(2);

        reset_state_test();
        single_transfer_test();
        stream_test();
        dropped_update_test();
        no_update_test();

        $display("Errors: %0d (mismatches %0d, timeouts %0d), data_valid pulses %0d",
                 mismatch_count + timeout_count, mismatch_count, timeout_count, pulse_count);
        if (mismatch_count + timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/cdc_pkg.sv
hdl/toggle_sync.sv
hdl/src_capture.sv
hdl/dst_capture.sv
hdl/multibit_toggle_sync.sv
verif/tb_multibit_toggle_sync.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CDC bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module tb_multibit_toggle_sync \
    -f compile.f \
    -o tb_sim

./obj_dir/tb_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

exit 0
